/* Bender.yml */
package:
  name: cnn_top

sources:
  - files:
      - source/cnn_geometry_pkg.sv
      - source/cnn_types_pkg.sv
      - source/cnn_sequencer.sv
      - source/kernel_store.sv
      - source/window_buffer.sv
      - source/conv_array.sv
      - source/cnn_top.sv
  - target: test
    files:
      - dv/cnn_assertions.sv
      - dv/cnn_tb.sv

/* cnn_top.f */
source/cnn_geometry_pkg.sv
source/cnn_types_pkg.sv
source/cnn_sequencer.sv
source/kernel_store.sv
source/window_buffer.sv
source/conv_array.sv
source/cnn_top.sv
dv/cnn_assertions.sv
dv/cnn_tb.sv

/* dv/cnn_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_assertions (
    input logic clk,
    input logic rstn,
    input logic start_cnn,
    input logic weight_tready,
    input logic image_tvalid,
    input logic image_tready,
    input logic result_tvalid,
    input logic cnn_done
);
    import cnn_geometry_pkg::*;

    int                      fail_count = 0;
    logic                    start_prev;
    logic                    start_seen;   // start edge since reset or last done
    logic [POS_W-1:0]        pos_row;
    logic [POS_W-1:0]        pos_col;
    logic [RESULT_CNT_W-1:0] res_cnt;
    logic                    img_hs;
    logic                    win_pixel;
    logic                    last_result;

    assign img_hs      = image_tvalid && image_tready;
    assign win_pixel   = img_hs && (pos_row >= POS_W'(KERNEL_W - 1))
                                && (pos_col >= POS_W'(KERNEL_W - 1));
    assign last_result = result_tvalid && (res_cnt == RESULT_CNT_W'(RESULT_COUNT - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_prev <= 1'b0;
            start_seen <= 1'b0;
            pos_row    <= '0;
            pos_col    <= '0;
            res_cnt    <= '0;
        end else begin
            start_prev <= start_cnn;
            if (start_cnn && !start_prev)
                start_seen <= 1'b1;
            else if (cnn_done)
                start_seen <= 1'b0;
            if (img_hs) begin
                pos_col <= (pos_col == POS_W'(IMG_W - 1)) ? '0 : pos_col + 1'b1;
                if (pos_col == POS_W'(IMG_W - 1))
                    pos_row <= (pos_row == POS_W'(IMG_W - 1)) ? '0 : pos_row + 1'b1;
            end
            if (result_tvalid)
                res_cnt <= last_result ? '0 : res_cnt + 1'b1;
        end
    end

    idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
        !start_seen |-> !weight_tready && !image_tready && !result_tvalid && !cnn_done)
        else begin $error("stream or done active without a start edge"); fail_count++; end

    ready_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(weight_tready && image_tready))
        else begin $error("weight and image ready high together"); fail_count++; end

    result_after_window: assert property (@(posedge clk) disable iff (!rstn)
        win_pixel |-> ##3 result_tvalid)
        else begin $error("no result three cycles after a window pixel"); fail_count++; end

    result_has_window: assert property (@(posedge clk) disable iff (!rstn)
        result_tvalid |-> $past(win_pixel, 3))
        else begin $error("result without a window pixel three cycles earlier"); fail_count++; end

    done_after_last: assert property (@(posedge clk) disable iff (!rstn)
        last_result |=> cnn_done)
        else begin $error("done missing after the last result"); fail_count++; end

    done_has_last: assert property (@(posedge clk) disable iff (!rstn)
        cnn_done |-> $past(last_result))
        else begin $error("done without a last result before it"); fail_count++; end

    done_single: assert property (@(posedge clk) disable iff (!rstn)
        cnn_done |=> !cnn_done)
        else begin $error("done longer than one cycle"); fail_count++; end

endmodule

bind cnn_top cnn_assertions cnn_assertions_inst (
    .clk          (clk),
    .rstn         (rstn),
    .start_cnn    (start_cnn),
    .weight_tready(weight_tready),
    .image_tvalid (image_tvalid),
    .image_tready (image_tready),
    .result_tvalid(result_tvalid),
    .cnn_done     (cnn_done)
);

`default_nettype wire

/* dv/cnn_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_tb;
    import cnn_geometry_pkg::*;
    import cnn_types_pkg::*;

    localparam int CYCLE_LIMIT = 3000;  // about 3 runs x 224 cycles x 4 for gaps

    logic    clk;
    logic    rstn;
    logic    start_cnn;
    logic    weight_tvalid;
    logic    weight_tdata;
    logic    weight_tready;
    logic    image_tvalid;
    pixel_t  image_tdata;
    logic    image_tready;
    logic    result_tvalid;
    result_t result_tdata;
    logic    cnn_done;

    integer                  seed;
    int                      cycles;
    int                      errors;
    int                      res_idx;
    int                      weight_hs;
    logic                    img_ready_q;
    string                   test_name;
    logic [WEIGHT_COUNT-1:0] weights;
    pixel_t                  image [PIXEL_COUNT];
    pixel_t                  expected [RESULT_COUNT][CHANNELS];

    cnn_top cnn_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // window for output o starts at row o/4 and column o%4
    task automatic compute_expected();
        pixel_t acc;
        pixel_t p;
        for (int o = 0; o < RESULT_COUNT; o++) begin
            for (int c = 0; c < CHANNELS; c++) begin
                acc = '0;
                for (int t = 0; t < KERNEL_TAPS; t++) begin
                    p = image[(o / OUT_W + t / KERNEL_W) * IMG_W + o % OUT_W + t % KERNEL_W];
                    acc = weights[c*KERNEL_TAPS + t] ? acc + p : acc - p;  // bit 0 subtracts
                end
                expected[o][c] = acc;
            end
        end
    endtask

    task automatic randomize_stimulus();
        for (int i = 0; i < WEIGHT_COUNT; i++)
            weights[i] = ($random(seed) % 2) != 0;
        for (int i = 0; i < PIXEL_COUNT; i++)
            image[i] = $random(seed) % (1 << 20);
        compute_expected();
    endtask

    task automatic constant_stimulus(input pixel_t p);
        weights = '1;
        for (int i = 0; i < PIXEL_COUNT; i++)
            image[i] = p;
        for (int o = 0; o < RESULT_COUNT; o++)
            for (int c = 0; c < CHANNELS; c++)
                expected[o][c] = 25 * p;  // every tap added
    endtask

    task automatic send_weights(input bit gaps);
        int idx;
        bit taken;
        idx = 0;
        while (idx < WEIGHT_COUNT) begin
            @(posedge clk);
            taken = weight_tvalid && weight_tready;
            if (taken)
                idx++;
            if (idx == WEIGHT_COUNT) begin
                weight_tvalid <= 1'b0;
            end else if (taken || !weight_tvalid) begin  // held while waiting for ready
                weight_tvalid <= !gaps || ($random(seed) % 4 != 0);
                weight_tdata  <= weights[idx];
            end
        end
    endtask

    task automatic send_image(input bit gaps);
        int idx;
        bit taken;
        idx = 0;
        while (idx < PIXEL_COUNT) begin
            @(posedge clk);
            taken = image_tvalid && image_tready;
            if (taken)
                idx++;
            if (idx == PIXEL_COUNT) begin
                image_tvalid <= 1'b0;
            end else if (taken || !image_tvalid) begin
                image_tvalid <= !gaps || ($random(seed) % 4 != 0);
                image_tdata  <= image[idx];
            end
        end
    endtask

    task automatic run_test(input string name, input bit gaps);
        test_name = name;
        res_idx   = 0;
        @(posedge clk);
        start_cnn <= 1'b1;
        repeat (2) @(posedge clk);
        start_cnn <= 1'b0;
        fork
            send_weights(gaps);
            send_image(gaps);
        join
        do begin
            @(posedge clk);
        end while (!cnn_done);
        if (res_idx != RESULT_COUNT) begin
            $display("[FAIL] %s result count: expected %0d, actual %0d",
                     name, RESULT_COUNT, res_idx);
            errors++;
        end
    endtask

    // results arrive in row-major order
    always @(posedge clk) begin
        if (rstn && result_tvalid) begin
            if (res_idx >= RESULT_COUNT) begin
                $display("%s: result beat after the last one of the run", test_name);
                errors++;
            end else begin
                for (int c = 0; c < CHANNELS; c++) begin
                    if (result_tdata[c] !== expected[res_idx][c]) begin
                        $display("[FAIL] %s result %0d channel %0d: expected %0d, actual %0d",
                                 test_name, res_idx, c, expected[res_idx][c], result_tdata[c]);
                        errors++;
                    end
                end
            end
            res_idx++;
        end
    end

    // weight handshakes seen before image_tready rises
    always @(posedge clk) begin
        if (!rstn) begin
            weight_hs   = 0;
            img_ready_q = 1'b0;
        end else begin
            if (weight_tvalid && weight_tready)
                weight_hs++;
            if (image_tready && !img_ready_q) begin
                if (weight_hs != WEIGHT_COUNT) begin
                    $display("[FAIL] %s weight beats: expected %0d, actual %0d",
                             test_name, WEIGHT_COUNT, weight_hs);
                    errors++;
                end
                weight_hs = 0;
            end
            img_ready_q = image_tready;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d mismatches, %0d assertion failures",
                     errors, cnn_top_inst.cnn_assertions_inst.fail_count);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        seed          = 32'h9216cf2a;
        cycles        = 0;
        errors        = 0;
        res_idx       = 0;
        test_name     = "reset";
        rstn          = 1'b0;
        start_cnn     = 1'b0;
        weight_tvalid = 1'b0;
        weight_tdata  = 1'b0;
        image_tvalid  = 1'b0;
        image_tdata   = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        repeat (3) @(posedge clk);

        randomize_stimulus();
        run_test("stream_no_gaps", 1'b0);
        randomize_stimulus();
        run_test("stream_random_gaps", 1'b1);
        constant_stimulus(-32'sd12345);
        run_test("ones_constant", 1'b0);

        repeat (5) @(posedge clk);
        $display("errors: %0d mismatches, %0d assertion failures",
                 errors, cnn_top_inst.cnn_assertions_inst.fail_count);
        if (errors == 0 && cnn_top_inst.cnn_assertions_inst.fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/cnn_geometry_pkg.sv */
`default_nettype none

package cnn_geometry_pkg;

    // input image, square
    localparam int IMG_W    = 8;
    localparam int PIXEL_W  = 32;

    // binary kernels, one per output channel
    localparam int KERNEL_W = 5;
    localparam int CHANNELS = 6;

    // valid convolution, no padding
    localparam int OUT_W = IMG_W - KERNEL_W + 1;

    localparam int KERNEL_TAPS  = KERNEL_W * KERNEL_W;
    localparam int WEIGHT_COUNT = CHANNELS * KERNEL_TAPS;    // weight bits per run
    localparam int PIXEL_COUNT  = IMG_W * IMG_W;
    localparam int RESULT_COUNT = OUT_W * OUT_W;

    // counter widths
    localparam int WEIGHT_CNT_W = $clog2(WEIGHT_COUNT);
    localparam int PIXEL_CNT_W  = $clog2(PIXEL_COUNT);
    localparam int RESULT_CNT_W = $clog2(RESULT_COUNT);
    localparam int POS_W        = $clog2(IMG_W);           // row / column index

endpackage

`default_nettype wire

/* source/cnn_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_sequencer (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       start_cnn,
    input  logic                       weight_tvalid,
    input  logic                       image_tvalid,
    input  cnn_types_pkg::pixel_t      image_tdata,
    input  logic                       result_valid,
    output logic                       weight_tready,
    output logic                       image_tready,
    output logic                       weight_accept,
    output cnn_types_pkg::pixel_beat_t pixel_beat,
    output logic                       cnn_done
);
    import cnn_geometry_pkg::*;
    import cnn_types_pkg::*;

    seq_phase_e              phase;
    logic                    start_q1;
    logic                    start_q2;
    logic                    start_rise;
    logic                    pixel_accept;
    logic [WEIGHT_CNT_W-1:0] weight_cnt;
    logic [PIXEL_CNT_W-1:0]  pixel_cnt;
    logic [RESULT_CNT_W-1:0] result_cnt;
    logic                    weight_last;
    logic                    pixel_last;
    logic                    result_last;

    assign start_rise = start_q1 & ~start_q2;

    assign weight_tready = (phase == PH_LOAD_WEIGHTS);
    assign image_tready  = (phase == PH_STREAM_IMAGE);
    assign cnn_done      = (phase == PH_DONE);

    assign weight_accept = weight_tvalid & weight_tready;
    assign pixel_accept  = image_tvalid & image_tready;

    assign pixel_beat.valid = pixel_accept;
    assign pixel_beat.pixel = image_tdata;

    assign weight_last = (weight_cnt == WEIGHT_CNT_W'(WEIGHT_COUNT - 1));
    assign pixel_last  = (pixel_cnt == PIXEL_CNT_W'(PIXEL_COUNT - 1));
    assign result_last = (result_cnt == RESULT_CNT_W'(RESULT_COUNT - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_q1 <= 1'b0;
            start_q2 <= 1'b0;
        end else begin
            start_q1 <= start_cnn;
            start_q2 <= start_q1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase <= PH_IDLE;
        end else begin
            case (phase)
                PH_IDLE:         if (start_rise) phase <= PH_LOAD_WEIGHTS;  // edges mid-run ignored
                PH_LOAD_WEIGHTS: if (weight_accept && weight_last) phase <= PH_STREAM_IMAGE;
                PH_STREAM_IMAGE: if (pixel_accept && pixel_last) phase <= PH_DRAIN;
                PH_DRAIN:        if (result_valid && result_last) phase <= PH_DONE;
                default:         phase <= PH_IDLE;
            endcase
        end
    end

    // counters wrap on their last beat, so each run starts from zero
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            weight_cnt <= '0;
            pixel_cnt  <= '0;
            result_cnt <= '0;
        end else begin
            if (weight_accept)
                weight_cnt <= weight_last ? '0 : weight_cnt + 1'b1;
            if (pixel_accept)
                pixel_cnt <= pixel_last ? '0 : pixel_cnt + 1'b1;
            if (result_valid)
                result_cnt <= result_last ? '0 : result_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/cnn_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start_cnn,
    input  logic                   weight_tvalid,
    input  logic                   weight_tdata,
    output logic                   weight_tready,
    input  logic                   image_tvalid,
    input  cnn_types_pkg::pixel_t  image_tdata,
    output logic                   image_tready,
    output logic                   result_tvalid,
    output cnn_types_pkg::result_t result_tdata,
    output logic                   cnn_done
);
    import cnn_types_pkg::*;

    logic         weight_accept;
    pixel_beat_t  pixel_beat;
    window_beat_t window_beat;
    kernel_bank_t kernels;

    cnn_sequencer cnn_sequencer_inst (
        .clk          (clk),
        .rstn         (rstn),
        .start_cnn    (start_cnn),
        .weight_tvalid(weight_tvalid),
        .image_tvalid (image_tvalid),
        .image_tdata  (image_tdata),
        .result_valid (result_tvalid),   // counted toward the end of run
        .weight_tready(weight_tready),
        .image_tready (image_tready),
        .weight_accept(weight_accept),
        .pixel_beat   (pixel_beat),
        .cnn_done     (cnn_done)
    );

    kernel_store kernel_store_inst (
        .clk          (clk),
        .rstn         (rstn),
        .weight_accept(weight_accept),
        .weight_bit   (weight_tdata),
        .kernels      (kernels)
    );

    window_buffer window_buffer_inst (
        .clk        (clk),
        .rstn       (rstn),
        .pixel_beat (pixel_beat),
        .window_beat(window_beat)
    );

    conv_array conv_array_inst (
        .clk         (clk),
        .rstn        (rstn),
        .window_beat (window_beat),
        .kernels     (kernels),
        .result_valid(result_tvalid),
        .result      (result_tdata)
    );

endmodule

`default_nettype wire

/* source/cnn_types_pkg.sv */
`default_nettype none

package cnn_types_pkg;

    import cnn_geometry_pkg::*;

    // pixels and channel sums share one signed word
    typedef logic signed [PIXEL_W-1:0] pixel_t;

    // 5x5 window, row-major, tap 0 is the top-left pixel
    typedef pixel_t [KERNEL_TAPS-1:0] window_t;

    // bit c*25+k is channel c, tap k
    typedef logic [WEIGHT_COUNT-1:0] kernel_bank_t;

    typedef struct packed {
        logic   valid;
        pixel_t pixel;
    } pixel_beat_t;

    typedef struct packed {
        logic    valid;
        window_t window;
    } window_beat_t;

    // channel 0 in the low word
    typedef pixel_t [CHANNELS-1:0] result_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LOAD_WEIGHTS,
        PH_STREAM_IMAGE,
        PH_DRAIN,
        PH_DONE
    } seq_phase_e;

endpackage

`default_nettype wire

/* source/conv_array.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_array (
    input  logic                        clk,
    input  logic                        rstn,
    input  cnn_types_pkg::window_beat_t window_beat,
    input  cnn_types_pkg::kernel_bank_t kernels,
    output logic                        result_valid,
    output cnn_types_pkg::result_t      result
);
    import cnn_geometry_pkg::*;
    import cnn_types_pkg::*;

    pixel_t  row_sum_d [CHANNELS][KERNEL_W];
    pixel_t  row_sum_q [CHANNELS][KERNEL_W];
    logic    s1_valid_q;
    result_t result_d;

    // stage 1: +/- pixel per weight bit, one sum per channel and kernel row
    always_comb begin
        for (int c = 0; c < CHANNELS; c++) begin
            for (int r = 0; r < KERNEL_W; r++) begin
                row_sum_d[c][r] = '0;
                for (int k = 0; k < KERNEL_W; k++) begin
                    if (kernels[c*KERNEL_TAPS + r*KERNEL_W + k])
                        row_sum_d[c][r] = row_sum_d[c][r] + window_beat.window[r*KERNEL_W+k];
                    else
                        row_sum_d[c][r] = row_sum_d[c][r] - window_beat.window[r*KERNEL_W+k];
                end
            end
        end
    end

    // stage 2: five row sums per channel, wraps at 32 bits
    always_comb begin
        for (int c = 0; c < CHANNELS; c++) begin
            result_d[c] = '0;
            for (int r = 0; r < KERNEL_W; r++) begin
                result_d[c] = result_d[c] + row_sum_q[c][r];
            end
        end
    end

    always_ff @(posedge clk) begin
        row_sum_q <= row_sum_d;
        result    <= result_d;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid_q   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid_q   <= window_beat.valid;
            result_valid <= s1_valid_q;
        end
    end

endmodule

`default_nettype wire

/* source/kernel_store.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_store (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        weight_accept,
    input  logic                        weight_bit,
    output cnn_types_pkg::kernel_bank_t kernels
);
    import cnn_geometry_pkg::*;

    // bits enter at the top and move down one place per beat, so the
    // first weight of a 150-bit load ends up in bit 0 (channel 0, tap 0)
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            kernels <= '0;
        end else if (weight_accept) begin
            kernels <= {weight_bit, kernels[WEIGHT_COUNT-1:1]};
        end
    end

endmodule

`default_nettype wire

/* source/window_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module window_buffer (
    input  logic                        clk,
    input  logic                        rstn,
    input  cnn_types_pkg::pixel_beat_t  pixel_beat,
    output cnn_types_pkg::window_beat_t window_beat
);
    import cnn_geometry_pkg::*;
    import cnn_types_pkg::*;

    // line_buf[j] holds image row (row - 1 - j)
    pixel_t                  line_buf [KERNEL_W-1][IMG_W];
    pixel_t [KERNEL_W-1:0]   col_vec;
    window_t                 window_q;
    logic                    win_valid_q;
    logic [POS_W-1:0]        row;
    logic [POS_W-1:0]        col;
    logic                    col_last;
    logic                    win_complete;

    assign col_last     = (col == POS_W'(IMG_W - 1));
    assign win_complete = (row >= POS_W'(KERNEL_W - 1)) && (col >= POS_W'(KERNEL_W - 1));

    // new window column, oldest row on top
    always_comb begin
        for (int r = 0; r < KERNEL_W - 1; r++) begin
            col_vec[r] = line_buf[KERNEL_W-2-r][col];
        end
        col_vec[KERNEL_W-1] = pixel_beat.pixel;
    end

    always_ff @(posedge clk) begin
        if (pixel_beat.valid) begin
            line_buf[0][col] <= pixel_beat.pixel;
            for (int j = 1; j < KERNEL_W - 1; j++) begin
                line_buf[j][col] <= line_buf[j-1][col];
            end
            // shift left, new column in on the right
            for (int r = 0; r < KERNEL_W; r++) begin
                for (int c = 0; c < KERNEL_W - 1; c++) begin
                    window_q[r*KERNEL_W+c] <= window_q[r*KERNEL_W+c+1];
                end
                window_q[r*KERNEL_W+KERNEL_W-1] <= col_vec[r];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row         <= '0;
            col         <= '0;
            win_valid_q <= 1'b0;
        end else begin
            win_valid_q <= pixel_beat.valid && win_complete;
            if (pixel_beat.valid) begin
                col <= col_last ? '0 : col + 1'b1;
                if (col_last)
                    row <= (row == POS_W'(IMG_W - 1)) ? '0 : row + 1'b1;  // back to 0,0
            end
        end
    end

    assign window_beat.valid  = win_valid_q;
    assign window_beat.window = window_q;

endmodule

`default_nettype wire
